/* list.f */
logic/dmiss_pkg.sv
logic/dmiss_req_stage.sv
logic/dmiss_half.sv
logic/dmiss_issue_ctrl.sv
logic/dmiss_cam.sv
sim/dmiss_checker.sv
sim/dmiss_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       := dmiss_tb
FILELIST  := list.f
LOG       := sim.log
OBJDIR    := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o $(TOP)
	./$(OBJDIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || (echo "simulation did not finish"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* sim/dmiss_tb.sv */
`timescale 1ns/100ps

module dmiss_tb;

  logic clk;
  logic rst;
  dmiss_pkg::miss_req_t miss_req [dmiss_pkg::NUM_PORTS];
  logic resolve_valid;
  dmiss_pkg::entry_id_t resolve_id;
  logic unlock;
  logic mem_req_valid;
  dmiss_pkg::entry_id_t mem_req_id;
  dmiss_pkg::miss_entry_t mem_req;
  dmiss_pkg::line_addr_t resolve_addr;
  logic has_free;
  logic locked;
  logic replay_start;
  dmiss_pkg::entry_id_t pending [$];
  int timeouts = 0;
  int tests = 0;
  int failed = 0;
  int seen = 0;

  dmiss_cam dut_i (
    .clk, .rst, .miss_req_i(miss_req), .resolve_valid_i(resolve_valid),
    .resolve_id_i(resolve_id), .unlock_i(unlock), .mem_req_valid_o(mem_req_valid),
    .mem_req_id_o(mem_req_id), .mem_req_o(mem_req), .resolve_addr_o(resolve_addr),
    .has_free_o(has_free), .locked_o(locked), .replay_start_o(replay_start)
  );

  dmiss_checker chk_i (
    .clk, .rst, .miss_req_i(miss_req), .resolve_valid_i(resolve_valid),
    .resolve_id_i(resolve_id), .unlock_i(unlock), .mem_req_valid_i(mem_req_valid),
    .mem_req_id_i(mem_req_id), .mem_req_i(mem_req), .resolve_addr_i(resolve_addr),
    .locked_i(locked), .replay_start_i(replay_start)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    if (!rst && mem_req_valid) pending.push_back(mem_req_id);
  end

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge clk);
      miss_req[0].valid = 1'b0;
      miss_req[1].valid = 1'b0;
    end
  endtask

  // six even and six odd lines per batch keep both halves below full
  task automatic send_batch(input dmiss_pkg::line_addr_t base, input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      for (int p = 0; p < dmiss_pkg::NUM_PORTS; p++) begin
        miss_req[p].valid = ($urandom % 4) != 0;
        miss_req[p].addr = base + dmiss_pkg::line_addr_t'($urandom % 12);
        miss_req[p].meta = dmiss_pkg::miss_meta_t'($urandom);
      end
    end
    idle(1);
  endtask

  task automatic drain_until_replay();
    int n;
    n = 0;
    while (n < 400) begin
      @(negedge clk);
      resolve_valid = 1'b0;
      if (replay_start) break;
      resolve_valid = pending.size() > 0;
      if (pending.size() > 0) resolve_id = pending.pop_front();
      n++;
    end
    @(negedge clk);
    resolve_valid = 1'b0;
    if (n >= 400) begin
      timeouts++;
      $display("Timeout: replay never started after all responses");
    end
  endtask

  task automatic wait_locked();
    int n;
    n = 0;
    while (!locked && n < 100) begin
      @(negedge clk);
      n++;
    end
    if (!locked) begin
      timeouts++;
      $display("Timeout: buffer never locked");
    end
  endtask

  task automatic pulse_unlock();
    idle(2);
    @(negedge clk);
    unlock = 1'b1;
    @(negedge clk);
    unlock = 1'b0;
    pending.delete();
    idle(2);
  endtask

  task automatic report_test(input string name);
    int now;
    now = chk_i.errors + timeouts;
    tests++;
    if (now != seen) failed++;
    $display("test %s: %s", name, (now == seen) ? "ok" : "failed");
    seen = now;
  endtask

  function automatic dmiss_pkg::line_addr_t random_base();
    return dmiss_pkg::line_addr_t'({$urandom, $urandom}) & ~dmiss_pkg::line_addr_t'(31);
  endfunction

  initial begin
    dmiss_pkg::line_addr_t base;
    void'($urandom(55));
    rst = 1'b1;
    miss_req[0] = '0;
    miss_req[1] = '0;
    resolve_valid = 1'b0;
    resolve_id = '0;
    unlock = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    chk_i.compare("mem_req_valid_o", 64'(mem_req_valid), 64'(0));
    chk_i.compare("locked_o", 64'(locked), 64'(0));
    chk_i.compare("replay_start_o", 64'(replay_start), 64'(0));
    chk_i.compare("has_free_o", 64'(has_free), 64'(1));
    report_test("reset");

    for (int b = 0; b < 4; b++) begin
      send_batch(random_base(), 20 + b * 5);
      drain_until_replay();
      wait_locked();
      if (b == 3) begin
        // fills sent while locked must be dropped
        send_batch(random_base(), 6);
      end
      pulse_unlock();
      report_test($sformatf("random traffic %0d", b));
    end

    base = random_base();
    for (int i = 0; i < 9; i++) begin
      @(negedge clk);
      miss_req[0].valid = 1'b1;
      miss_req[0].addr = base + dmiss_pkg::line_addr_t'(2 * i);
      miss_req[0].meta = dmiss_pkg::miss_meta_t'($urandom);
      miss_req[1].valid = 1'b0;
    end
    idle(1);
    wait_locked();
    chk_i.compare("has_free_o", 64'(has_free), 64'(0));
    pulse_unlock();
    chk_i.compare("has_free_o", 64'(has_free), 64'(1));
    send_batch(random_base(), 15);
    drain_until_replay();
    wait_locked();
    pulse_unlock();
    report_test("full half and unlock");

    $display("tests %0d, failed %0d, errors %0d", tests, failed, chk_i.errors + timeouts);
    if (chk_i.errors + timeouts == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* sim/dmiss_checker.sv */
`timescale 1ns/100ps

module dmiss_checker (
  input logic                   clk,
  input logic                   rst,
  input dmiss_pkg::miss_req_t   miss_req_i [dmiss_pkg::NUM_PORTS],
  input logic                   resolve_valid_i,
  input dmiss_pkg::entry_id_t   resolve_id_i,
  input logic                   unlock_i,
  input logic                   mem_req_valid_i,
  input dmiss_pkg::entry_id_t   mem_req_id_i,
  input dmiss_pkg::miss_entry_t mem_req_i,
  input dmiss_pkg::line_addr_t  resolve_addr_i,
  input logic                   locked_i,
  input logic                   replay_start_i
);

  int errors = 0;
  dmiss_pkg::miss_meta_t sent_meta [dmiss_pkg::line_addr_t];
  int issue_cnt [dmiss_pkg::line_addr_t];
  dmiss_pkg::line_addr_t id_addr [dmiss_pkg::NUM_ENTRIES];
  dmiss_pkg::entry_mask_t issued_ids;
  dmiss_pkg::entry_mask_t resolved_ids;
  logic replayed;
  logic unlock_prev;
  int quiet;
  int last_id;

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic note(input string msg);
    errors++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  task automatic clear_epoch();
    sent_meta.delete();
    issue_cnt.delete();
    issued_ids = '0;
    resolved_ids = '0;
    replayed = 1'b0;
    last_id = -1;
  endtask

  always @(posedge clk) begin
    if (rst) begin
      clear_epoch();
      unlock_prev = 1'b0;
      quiet = 0;
    end else begin
      // the first accepted send of a line decides the metadata it keeps
      for (int p = 0; p < dmiss_pkg::NUM_PORTS; p++) begin
        if (miss_req_i[p].valid && !locked_i && !sent_meta.exists(miss_req_i[p].addr)) begin
          sent_meta[miss_req_i[p].addr] = miss_req_i[p].meta;
        end
      end
      // once replay has started the buffer holds its lock until the unlock
      if (replayed) compare("locked_o", 64'(locked_i), 64'(1));
      if (unlock_prev) compare("locked_o", 64'(locked_i), 64'(0));
      if (mem_req_valid_i) begin
        if (locked_i && replayed) note("memory request while locked after replay");
        compare("mem_req_id_o[3]", 64'(mem_req_id_i[3]), 64'(mem_req_i.addr[0]));
        if (issued_ids[mem_req_id_i]) note("entry issued twice");
        if (!sent_meta.exists(mem_req_i.addr)) begin
          note("issued line was never requested");
        end else begin
          compare("mem_req_o.meta", 64'(mem_req_i.meta), 64'(sent_meta[mem_req_i.addr]));
        end
        if (issue_cnt.exists(mem_req_i.addr)) note("line issued twice");
        issue_cnt[mem_req_i.addr] = 1;
        // with no allocation in between, ids must come out lowest first
        if (quiet >= 2 && last_id >= 0 && int'(mem_req_id_i) <= last_id) begin
          note("entries issued out of lowest-ready order");
        end
        last_id = (quiet >= 2) ? int'(mem_req_id_i) : -1;
        issued_ids[mem_req_id_i] = 1'b1;
        id_addr[mem_req_id_i] = mem_req_i.addr;
      end
      if (resolve_valid_i) begin
        if (!issued_ids[resolve_id_i]) begin
          note("response for an entry that was never issued");
        end else begin
          compare("resolve_addr_o", 64'(resolve_addr_i), 64'(id_addr[resolve_id_i]));
        end
        resolved_ids[resolve_id_i] = 1'b1;
      end
      if (replay_start_i) begin
        if (replayed) note("second replay pulse in one lock period");
        if (resolved_ids != issued_ids) note("replay before every entry was resolved");
        compare("issued line count", 64'(issue_cnt.num()), 64'(sent_meta.num()));
        foreach (sent_meta[a]) begin
          if (!issue_cnt.exists(a)) note("requested line never issued");
        end
        replayed = 1'b1;
      end
      if (miss_req_i[0].valid || miss_req_i[1].valid) begin
        quiet = 0;
      end else if (quiet < 10) begin
        quiet++;
      end
      unlock_prev = unlock_i;
      if (unlock_i) clear_epoch();
    end
  end

endmodule

/* logic/dmiss_cam.sv */
`timescale 1ns/100ps

module dmiss_cam (
  input  logic                     clk,
  input  logic                     rst,
  input  dmiss_pkg::miss_req_t     miss_req_i [dmiss_pkg::NUM_PORTS],
  input  logic                     resolve_valid_i,
  input  dmiss_pkg::entry_id_t     resolve_id_i,
  input  logic                     unlock_i,
  output logic                     mem_req_valid_o,
  output dmiss_pkg::entry_id_t     mem_req_id_o,
  output dmiss_pkg::miss_entry_t   mem_req_o,
  output dmiss_pkg::line_addr_t    resolve_addr_o,
  output logic                     has_free_o,
  output logic                     locked_o,
  output logic                     replay_start_o
);

  dmiss_pkg::miss_req_t even_in [dmiss_pkg::NUM_PORTS];
  dmiss_pkg::miss_req_t odd_in [dmiss_pkg::NUM_PORTS];
  dmiss_pkg::miss_req_t even_stg [dmiss_pkg::NUM_PORTS];
  dmiss_pkg::miss_req_t odd_stg [dmiss_pkg::NUM_PORTS];
  logic [dmiss_pkg::NUM_PORTS-1:0] even_hit;
  logic [dmiss_pkg::NUM_PORTS-1:0] odd_hit;
  dmiss_pkg::half_mask_t even_busy, odd_busy;
  dmiss_pkg::half_mask_t even_waiting, odd_waiting;
  dmiss_pkg::half_mask_t even_issued, odd_issued;
  dmiss_pkg::half_mask_t even_alloc, odd_alloc;
  dmiss_pkg::half_mask_t even_issue, odd_issue;
  dmiss_pkg::miss_entry_t even_entries [dmiss_pkg::HALF_ENTRIES];
  dmiss_pkg::miss_entry_t odd_entries [dmiss_pkg::HALF_ENTRIES];
  logic even_full, odd_full;
  logic alloc_block, free_all;

  dmiss_req_stage stage_i (
    .clk, .rst, .miss_req_i,
    .even_hit_i(even_hit), .odd_hit_i(odd_hit),
    .even_in_o(even_in), .odd_in_o(odd_in),
    .even_stg_o(even_stg), .odd_stg_o(odd_stg)
  );

  //////////////////////////////
  // the two halves
  //////////////////////////////

  dmiss_half #(.HALF_SEL(1'b0)) even_i (
    .clk, .rst, .in_i(even_in), .hit_o(even_hit), .stg_i(even_stg),
    .alloc_block_i(alloc_block), .issue_mask_i(even_issue),
    .resolve_valid_i, .resolve_id_i, .free_all_i(free_all),
    .busy_o(even_busy), .waiting_o(even_waiting), .issued_o(even_issued),
    .alloc_o(even_alloc), .full_o(even_full), .entries_o(even_entries)
  );

  dmiss_half #(.HALF_SEL(1'b1)) odd_i (
    .clk, .rst, .in_i(odd_in), .hit_o(odd_hit), .stg_i(odd_stg),
    .alloc_block_i(alloc_block), .issue_mask_i(odd_issue),
    .resolve_valid_i, .resolve_id_i, .free_all_i(free_all),
    .busy_o(odd_busy), .waiting_o(odd_waiting), .issued_o(odd_issued),
    .alloc_o(odd_alloc), .full_o(odd_full), .entries_o(odd_entries)
  );

  dmiss_issue_ctrl ctrl_i (
    .clk, .rst,
    .even_busy_i(even_busy), .odd_busy_i(odd_busy),
    .even_waiting_i(even_waiting), .odd_waiting_i(odd_waiting),
    .even_issued_i(even_issued), .odd_issued_i(odd_issued),
    .even_alloc_i(even_alloc), .odd_alloc_i(odd_alloc),
    .even_full_i(even_full), .odd_full_i(odd_full),
    .even_entries_i(even_entries), .odd_entries_i(odd_entries),
    .resolve_id_i, .unlock_i,
    .even_issue_o(even_issue), .odd_issue_o(odd_issue),
    .alloc_block_o(alloc_block), .free_all_o(free_all),
    .mem_req_valid_o, .mem_req_id_o, .mem_req_o, .resolve_addr_o,
    .has_free_o, .locked_o, .replay_start_o
  );

endmodule

/* logic/dmiss_issue_ctrl.sv */
`timescale 1ns/100ps

module dmiss_issue_ctrl (
  input  logic                        clk,
  input  logic                        rst,
  input  dmiss_pkg::half_mask_t       even_busy_i,
  input  dmiss_pkg::half_mask_t       odd_busy_i,
  input  dmiss_pkg::half_mask_t       even_waiting_i,
  input  dmiss_pkg::half_mask_t       odd_waiting_i,
  input  dmiss_pkg::half_mask_t       even_issued_i,
  input  dmiss_pkg::half_mask_t       odd_issued_i,
  input  dmiss_pkg::half_mask_t       even_alloc_i,
  input  dmiss_pkg::half_mask_t       odd_alloc_i,
  input  logic                        even_full_i,
  input  logic                        odd_full_i,
  input  dmiss_pkg::miss_entry_t      even_entries_i [dmiss_pkg::HALF_ENTRIES],
  input  dmiss_pkg::miss_entry_t      odd_entries_i [dmiss_pkg::HALF_ENTRIES],
  input  dmiss_pkg::entry_id_t        resolve_id_i,
  input  logic                        unlock_i,
  output dmiss_pkg::half_mask_t       even_issue_o,
  output dmiss_pkg::half_mask_t       odd_issue_o,
  output logic                        alloc_block_o,
  output logic                        free_all_o,
  output logic                        mem_req_valid_o,
  output dmiss_pkg::entry_id_t        mem_req_id_o,
  output dmiss_pkg::miss_entry_t      mem_req_o,
  output dmiss_pkg::line_addr_t       resolve_addr_o,
  output logic                        has_free_o,
  output logic                        locked_o,
  output logic                        replay_start_o
);

  dmiss_pkg::ctrl_state_t state_q;
  dmiss_pkg::ctrl_state_t state_nxt;
  dmiss_pkg::entry_mask_t ready;
  dmiss_pkg::entry_mask_t issue_mask;
  dmiss_pkg::entry_id_t issue_id;
  logic locked_q;
  logic was_locked_q;

  //////////////////////////////
  // memory request issue
  //////////////////////////////

  assign ready = {odd_busy_i & odd_waiting_i & ~odd_issued_i,
                  even_busy_i & even_waiting_i & ~even_issued_i};
  assign issue_mask = ready & (~ready + 1'b1);

  always_comb begin
    issue_id = '0;
    for (int i = dmiss_pkg::NUM_ENTRIES - 1; i >= 0; i--) begin
      if (ready[i]) begin
        issue_id = dmiss_pkg::entry_id_t'(i);
      end
    end
  end

  assign even_issue_o = issue_mask[dmiss_pkg::HALF_ENTRIES-1:0];
  assign odd_issue_o = issue_mask[dmiss_pkg::NUM_ENTRIES-1:dmiss_pkg::HALF_ENTRIES];
  assign mem_req_valid_o = |ready;
  assign mem_req_id_o = issue_id;
  assign mem_req_o = issue_id[3] ? odd_entries_i[issue_id[2:0]] : even_entries_i[issue_id[2:0]];

  assign resolve_addr_o = resolve_id_i[3] ? odd_entries_i[resolve_id_i[2:0]].addr :
                                            even_entries_i[resolve_id_i[2:0]].addr;

  //////////////////////////////
  // lock and replay
  //////////////////////////////

  // replay once every allocated line has been sent out and answered
  assign replay_start_o = (state_q == dmiss_pkg::DRAIN) &&
                          !(|{odd_waiting_i, even_waiting_i}) && !(|ready);

  always_comb begin
    state_nxt = state_q;
    case (state_q)
      dmiss_pkg::COLLECT: if (|{odd_alloc_i, even_alloc_i}) state_nxt = dmiss_pkg::DRAIN;
      dmiss_pkg::DRAIN: if (replay_start_o) state_nxt = dmiss_pkg::REPLAY_LOCK;
      default: state_nxt = state_q;
    endcase
    if (unlock_i) begin
      state_nxt = dmiss_pkg::COLLECT;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= dmiss_pkg::COLLECT;
      locked_q <= 1'b0;
      was_locked_q <= 1'b0;
    end else begin
      state_q <= state_nxt;
      locked_q <= (locked_q | even_full_i | odd_full_i | replay_start_o) & ~unlock_i;
      was_locked_q <= locked_q;
    end
  end

  // a staged request sampled while locked must not land after the unlock
  assign alloc_block_o = locked_q | was_locked_q | replay_start_o;
  assign free_all_o = unlock_i;
  assign has_free_o = ~(even_full_i | odd_full_i);
  assign locked_o = locked_q;

endmodule

/* logic/dmiss_half.sv */
`timescale 1ns/100ps

module dmiss_half #(
  parameter bit HALF_SEL = 1'b0
) (
  input  logic                             clk,
  input  logic                             rst,
  input  dmiss_pkg::miss_req_t             in_i [dmiss_pkg::NUM_PORTS],
  output logic [dmiss_pkg::NUM_PORTS-1:0]  hit_o,
  input  dmiss_pkg::miss_req_t             stg_i [dmiss_pkg::NUM_PORTS],
  input  logic                             alloc_block_i,
  input  dmiss_pkg::half_mask_t            issue_mask_i,
  input  logic                             resolve_valid_i,
  input  dmiss_pkg::entry_id_t             resolve_id_i,
  input  logic                             free_all_i,
  output dmiss_pkg::half_mask_t            busy_o,
  output dmiss_pkg::half_mask_t            waiting_o,
  output dmiss_pkg::half_mask_t            issued_o,
  output dmiss_pkg::half_mask_t            alloc_o,
  output logic                             full_o,
  output dmiss_pkg::miss_entry_t           entries_o [dmiss_pkg::HALF_ENTRIES]
);

  dmiss_pkg::miss_entry_t entries_q [dmiss_pkg::HALF_ENTRIES];
  dmiss_pkg::half_mask_t busy_q;
  dmiss_pkg::half_mask_t waiting_q;
  dmiss_pkg::half_mask_t issued_q;
  dmiss_pkg::half_mask_t first_free;
  dmiss_pkg::half_mask_t last_free;
  dmiss_pkg::half_mask_t grant0;
  dmiss_pkg::half_mask_t grant1;
  dmiss_pkg::half_mask_t res_clr;

  // an entry stays live until unlock, even after its response came back
  always_comb begin
    for (int p = 0; p < dmiss_pkg::NUM_PORTS; p++) begin
      hit_o[p] = 1'b0;
      for (int e = 0; e < dmiss_pkg::HALF_ENTRIES; e++) begin
        if (in_i[p].valid && busy_q[e] && entries_q[e].addr == in_i[p].addr) begin
          hit_o[p] = 1'b1;
        end
      end
    end
  end

  //////////////////////////////
  // allocation
  //////////////////////////////

  // port 0 searches from the bottom, port 1 from the top
  always_comb begin
    first_free = ~busy_q & (busy_q + 1'b1);
    last_free = '0;
    for (int e = 0; e < dmiss_pkg::HALF_ENTRIES; e++) begin
      if (!busy_q[e]) begin
        last_free = '0;
        last_free[e] = 1'b1;
      end
    end
    grant0 = (stg_i[0].valid && !alloc_block_i) ? first_free : '0;
    grant1 = '0;
    if (stg_i[1].valid && !alloc_block_i && last_free != grant0) begin
      grant1 = last_free;
    end
  end

  always_comb begin
    res_clr = '0;
    if (resolve_valid_i && resolve_id_i[3] == HALF_SEL) begin
      res_clr[resolve_id_i[2:0]] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || free_all_i) begin
      busy_q <= '0;
      waiting_q <= '0;
      issued_q <= '0;
    end else begin
      busy_q <= busy_q | grant0 | grant1;
      waiting_q <= (waiting_q | grant0 | grant1) & ~res_clr;
      issued_q <= issued_q | issue_mask_i;
    end
  end

  always_ff @(posedge clk) begin
    for (int e = 0; e < dmiss_pkg::HALF_ENTRIES; e++) begin
      if (grant0[e]) begin
        entries_q[e] <= {stg_i[0].addr, stg_i[0].meta};
      end else if (grant1[e]) begin
        entries_q[e] <= {stg_i[1].addr, stg_i[1].meta};
      end
    end
  end

  assign busy_o = busy_q;
  assign waiting_o = waiting_q;
  assign issued_o = issued_q;
  assign alloc_o = grant0 | grant1;
  assign full_o = &busy_q;
  assign entries_o = entries_q;

endmodule

/* logic/dmiss_req_stage.sv */
`timescale 1ns/100ps

module dmiss_req_stage (
  input  logic                                   clk,
  input  logic                                   rst,
  input  dmiss_pkg::miss_req_t                   miss_req_i [dmiss_pkg::NUM_PORTS],
  input  logic [dmiss_pkg::NUM_PORTS-1:0]        even_hit_i,
  input  logic [dmiss_pkg::NUM_PORTS-1:0]        odd_hit_i,
  output dmiss_pkg::miss_req_t                   even_in_o [dmiss_pkg::NUM_PORTS],
  output dmiss_pkg::miss_req_t                   odd_in_o [dmiss_pkg::NUM_PORTS],
  output dmiss_pkg::miss_req_t                   even_stg_o [dmiss_pkg::NUM_PORTS],
  output dmiss_pkg::miss_req_t                   odd_stg_o [dmiss_pkg::NUM_PORTS]
);

  dmiss_pkg::miss_req_t even_q [dmiss_pkg::NUM_PORTS];
  dmiss_pkg::miss_req_t odd_q [dmiss_pkg::NUM_PORTS];
  dmiss_pkg::miss_req_t even_nxt [dmiss_pkg::NUM_PORTS];
  dmiss_pkg::miss_req_t odd_nxt [dmiss_pkg::NUM_PORTS];
  logic [dmiss_pkg::NUM_PORTS-1:0] keep;

  // the halves see the raw requests so the entry match runs in this cycle
  always_comb begin
    for (int p = 0; p < dmiss_pkg::NUM_PORTS; p++) begin
      even_in_o[p] = miss_req_i[p];
      even_in_o[p].valid = miss_req_i[p].valid & ~miss_req_i[p].addr[0];
      odd_in_o[p] = miss_req_i[p];
      odd_in_o[p].valid = miss_req_i[p].valid & miss_req_i[p].addr[0];
    end
  end

  //////////////////////////////
  // duplicate filter
  //////////////////////////////

  always_comb begin
    for (int p = 0; p < dmiss_pkg::NUM_PORTS; p++) begin
      keep[p] = miss_req_i[p].valid;
      if (miss_req_i[p].addr[0] ? odd_hit_i[p] : even_hit_i[p]) begin
        keep[p] = 1'b0;
      end
      // a staged request is not in an entry yet but is already on its way
      for (int s = 0; s < dmiss_pkg::NUM_PORTS; s++) begin
        if (even_q[s].valid && even_q[s].addr == miss_req_i[p].addr) begin
          keep[p] = 1'b0;
        end
        if (odd_q[s].valid && odd_q[s].addr == miss_req_i[p].addr) begin
          keep[p] = 1'b0;
        end
      end
      // the lower port wins a same cycle tie
      for (int q = 0; q < p; q++) begin
        if (miss_req_i[q].valid && miss_req_i[q].addr == miss_req_i[p].addr) begin
          keep[p] = 1'b0;
        end
      end
      even_nxt[p] = miss_req_i[p];
      even_nxt[p].valid = keep[p] & ~miss_req_i[p].addr[0];
      odd_nxt[p] = miss_req_i[p];
      odd_nxt[p].valid = keep[p] & miss_req_i[p].addr[0];
    end
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < dmiss_pkg::NUM_PORTS; p++) begin
      if (rst) begin
        even_q[p].valid <= 1'b0;
        odd_q[p].valid <= 1'b0;
      end else begin
        even_q[p] <= even_nxt[p];
        odd_q[p] <= odd_nxt[p];
      end
    end
  end

  assign even_stg_o = even_q;
  assign odd_stg_o = odd_q;

endmodule

/* logic/dmiss_pkg.sv */
package dmiss_pkg;

  //////////////////////////////
  // sizes
  //////////////////////////////

  localparam int LINE_ADDR_W  = 37;
  localparam int NUM_PORTS    = 2;
  localparam int HALF_ENTRIES = 8;
  localparam int NUM_ENTRIES  = 16;

  // bit 0 of a line address picks the even or the odd half
  typedef logic [LINE_ADDR_W-1:0]  line_addr_t;
  // ids 0 to 7 live in the even half, 8 to 15 in the odd half
  typedef logic [3:0]              entry_id_t;
  typedef logic [HALF_ENTRIES-1:0] half_mask_t;
  typedef logic [NUM_ENTRIES-1:0]  entry_mask_t;
  typedef logic [4:0]              size_t;
  typedef logic [4:0]              bank_t;

  //////////////////////////////
  // request and entry content
  //////////////////////////////

  typedef struct packed {
    logic       store;
    size_t      size;
    logic       io;
    bank_t      bank;
    logic [1:0] low;
  } miss_meta_t;

  typedef struct packed {
    logic       valid;
    line_addr_t addr;
    miss_meta_t meta;
  } miss_req_t;

  typedef struct packed {
    line_addr_t addr;
    miss_meta_t meta;
  } miss_entry_t;

  typedef enum logic [1:0] {
    COLLECT,
    DRAIN,
    REPLAY_LOCK
  } ctrl_state_t;

endpackage
